// ==== include/snes_mem_config.svh ====
// Build-time constants for the memory-request front end
// Included by the package and by every RTL module that needs widths or port numbers

`ifndef SNES_MEM_CONFIG_SVH
`define SNES_MEM_CONFIG_SVH

// Byte address into the 8 MB SDRAM
`define SD_ADDR_W 23

// Work-RAM is 128 KB
`define WRAM_ADDR_W 17

// Top six byte-address bits that place work-RAM in the last 128 KB
`define WRAM_BANK_PREFIX 6'b111111

// CPU port numbers on the SDRAM controller
`define CPU_PORT_ROM 1'b0
`define CPU_PORT_WRAM 1'b1

`endif

// ==== rtl/snes_mem_pkg.sv ====
// Types shared by the SDRAM request front end
// Import with a wildcard in the module header of each block

`include "snes_mem_config.svh"

package snes_mem_pkg;

    typedef logic [7:0]                 byte_t;
    typedef logic [15:0]                sd_word_t;    // One SDRAM word
    typedef logic [`SD_ADDR_W-1:0]      sd_addr_t;    // SDRAM byte address
    typedef logic [`WRAM_ADDR_W-1:0]    wram_addr_t;
    typedef logic [31:0]                rv_word_t;    // Processor data

    // System-processor bridge sequencing
    typedef enum logic [2:0] {
        RV_IDLE_REQ0  = 3'd0,    // Idle, issue first half
        RV_WAIT0_REQ1 = 3'd1,    // Wait first, issue second half
        RV_DATA0      = 3'd2,    // Capture first read half
        RV_WAIT1      = 3'd3,
        RV_DATA1      = 3'd4
    } rv_state_t;

endpackage

// ==== rtl/rom_loader.sv ====
// ROM loader front end
// Pairs streamed loader bytes into 16-bit SDRAM writes, tracks the loaded state
// and derives the console run enable

`include "snes_mem_config.svh"

module rom_loader import snes_mem_pkg::*; (
    input  logic        mclk,
    input  logic        resetn,
    input  logic        loading,
    input  byte_t       loader_do,
    input  logic        loader_do_valid,
    input  logic        sdram_busy,
    input  logic        frame_pause,
    output logic        loader_wr,
    output sd_addr_t    loader_waddr,
    output sd_word_t    loader_wdata,
    output logic        loaded,
    output logic        enable
);
    logic     loading_r;
    sd_addr_t byte_addr;
    byte_t    prev_byte;    // Even byte waiting for its partner

    // Word write goes out with the odd byte
    assign loader_wr    = loading & loader_do_valid & byte_addr[0];
    assign loader_waddr = byte_addr;
    assign loader_wdata = {loader_do, prev_byte};

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            byte_addr <= '0;
            loaded    <= 1'b0;
            enable    <= 1'b0;
        end else begin
            loading_r <= loading;
            if (loader_do_valid)
                byte_addr <= byte_addr + `SD_ADDR_W'(1);
            if (loading & ~loading_r) begin    // Start of a new image
                byte_addr <= '0;
                loaded    <= 1'b0;
            end
            if (~loading & loading_r)
                loaded <= 1'b1;
            // Hold the console until memory is ready and the image is in
            enable <= ~sdram_busy & ~frame_pause & loaded;
        end
    end

    always_ff @(posedge mclk) begin
        if (loader_do_valid)
            prev_byte <= loader_do;
    end

endmodule

// ==== rtl/cpu_mem_req.sv ====
// Console request generator for the shared 16-bit CPU port of the SDRAM controller
// Loader writes, ROM reads and work-RAM accesses become cpu_req toggles;
// returned words are steered back to the console byte lanes

`include "snes_mem_config.svh"

module cpu_mem_req import snes_mem_pkg::*; (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    loading,
    input  logic                    loader_wr,
    input  sd_addr_t                loader_waddr,
    input  sd_word_t                loader_wdata,
    input  sd_addr_t                rom_addr,
    input  logic                    rom_ce_n,
    input  logic                    rom_word,
    input  wram_addr_t              wram_addr,
    input  logic                    wram_ce_n,
    input  logic                    wram_rd_n,
    input  logic                    wram_we_n,
    input  byte_t                   wram_d,
    input  sd_word_t                cpu_port0,
    input  sd_word_t                cpu_port1,
    output logic                    cpu_req,
    output logic [`SD_ADDR_W-2:0]   cpu_addr,
    output sd_word_t                cpu_din,
    output logic                    cpu_we,
    output logic [1:0]              cpu_ds,
    output logic                    cpu_port,
    output sd_word_t                rom_q,
    output byte_t                   wram_q
);
    logic       wram_rd;
    logic       wram_wr;
    logic       wram_rd_r;
    logic       wram_wr_r;
    wram_addr_t wram_addr_sd;    // Last work-RAM address sent
    sd_addr_t   rom_addr_sd;     // Last ROM address sent
    logic       rom_sd_vld;
    logic       wram_fire;
    logic       rom_fire;

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;

    // New word while reading, or a fresh read or write strobe
    assign wram_fire = (wram_rd && wram_addr[`WRAM_ADDR_W-1:1] != wram_addr_sd[`WRAM_ADDR_W-1:1])
                     || (wram_rd & ~wram_rd_r) || (wram_wr & ~wram_wr_r);
    assign rom_fire  = ~loading & ~rom_ce_n & (~rom_sd_vld | (rom_addr != rom_addr_sd));

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            cpu_req      <= 1'b0;
            wram_rd_r    <= 1'b0;
            wram_wr_r    <= 1'b0;
            wram_addr_sd <= '0;
            rom_sd_vld   <= 1'b0;
        end else begin
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;
            if (wram_fire | loader_wr | rom_fire)
                cpu_req <= ~cpu_req;
            if (wram_fire)
                wram_addr_sd <= wram_addr;
            if (loading)
                rom_sd_vld <= 1'b0;     // Image rewritten, forget the last ROM word
            else if (~wram_fire & rom_fire)
                rom_sd_vld <= 1'b1;
        end
    end

    // Request payload, work-RAM wins over ROM
    always_ff @(posedge mclk) begin
        if (wram_fire) begin
            cpu_addr <= {`WRAM_BANK_PREFIX, wram_addr[`WRAM_ADDR_W-1:1]};
            cpu_din  <= {wram_d, wram_d};
            cpu_we   <= wram_wr;
            cpu_ds   <= {wram_addr[0], ~wram_addr[0]};    // Odd byte is the high lane
            cpu_port <= `CPU_PORT_WRAM;
        end else if (loader_wr) begin
            cpu_addr <= loader_waddr[`SD_ADDR_W-1:1];
            cpu_din  <= loader_wdata;
            cpu_we   <= 1'b1;
            cpu_ds   <= 2'b11;
            cpu_port <= `CPU_PORT_ROM;
        end else if (rom_fire) begin
            rom_addr_sd <= rom_addr;
            cpu_addr    <= rom_addr[`SD_ADDR_W-1:1];
            cpu_we      <= 1'b0;
            cpu_ds      <= 2'b11;
            cpu_port    <= `CPU_PORT_ROM;
        end
    end

    // Byte reads at odd addresses want the high byte in the low lane
    assign rom_q  = (rom_word | ~rom_addr[0]) ? cpu_port0
                                              : {cpu_port0[7:0], cpu_port0[15:8]};
    assign wram_q = wram_addr[0] ? cpu_port1[15:8] : cpu_port1[7:0];

endmodule

// ==== rtl/rv_bridge.sv ====
// Bridge from the 32-bit system processor bus to the 16-bit SDRAM rv port
// Each access becomes one or two half-word toggle requests; rv_ready pulses once
// when the whole access is done

`include "snes_mem_config.svh"

module rv_bridge import snes_mem_pkg::*; (
    input  logic                    mclk,
    input  logic                    resetn,
    input  logic                    rv_valid,
    input  sd_addr_t                rv_addr,
    input  rv_word_t                rv_wdata,
    input  logic [3:0]              rv_wstrb,
    input  logic                    rv_req_ack,
    input  sd_word_t                rv_dout,
    output logic                    rv_ready,
    output rv_word_t                rv_rdata,
    output logic                    rv_req,
    output logic [`SD_ADDR_W-2:0]   rv_sd_addr,
    output sd_word_t                rv_din,
    output logic [1:0]              rv_ds,
    output logic                    rv_we
);
    rv_state_t rvst;
    logic      rv_valid_r;
    logic      rv_new_req;    // Request seen while still busy
    logic      new_edge;
    logic      rv_word;       // Upper half selected
    sd_word_t  rv_dout0;      // Lower read half

    assign new_edge   = rv_valid & ~rv_valid_r;
    assign rv_we      = |rv_wstrb;
    assign rv_sd_addr = {rv_addr[`SD_ADDR_W-1:2], rv_word};
    assign rv_din     = rv_word ? rv_wdata[31:16] : rv_wdata[15:0];
    assign rv_rdata   = {rv_dout, rv_dout0};

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            rvst       <= RV_IDLE_REQ0;
            rv_ready   <= 1'b0;
            rv_req     <= 1'b0;
            rv_valid_r <= 1'b0;
            rv_new_req <= 1'b0;
            rv_word    <= 1'b0;
            rv_ds      <= 2'b00;
        end else begin
            rv_ready   <= 1'b0;
            rv_valid_r <= rv_valid;
            if (new_edge)
                rv_new_req <= 1'b1;

            case (rvst)
                RV_IDLE_REQ0: begin
                    if (rv_new_req | new_edge) begin
                        rv_new_req <= 1'b0;
                        rv_req     <= ~rv_req;
                        if (rv_we && rv_wstrb[1:0] == 2'b00) begin
                            rv_word <= 1'b1;             // Upper half only
                            rv_ds   <= rv_wstrb[3:2];
                            rvst    <= RV_WAIT1;
                        end else begin
                            rv_word <= 1'b0;
                            rv_ds   <= rv_we ? rv_wstrb[1:0] : 2'b11;
                            rvst    <= RV_WAIT0_REQ1;
                        end
                    end
                end
                RV_WAIT0_REQ1: begin
                    if (rv_req == rv_req_ack) begin
                        rv_word <= 1'b1;
                        if (!rv_we) begin
                            rv_req <= ~rv_req;
                            rv_ds  <= 2'b11;
                            rvst   <= RV_DATA0;
                        end else if (rv_wstrb[3:2] == 2'b00) begin
                            rv_ready <= 1'b1;            // Lower half only, done
                            rvst     <= RV_IDLE_REQ0;
                        end else begin
                            rv_req <= ~rv_req;
                            rv_ds  <= rv_wstrb[3:2];
                            rvst   <= RV_WAIT1;
                        end
                    end
                end
                RV_DATA0:
                    rvst <= RV_WAIT1;
                RV_WAIT1: begin
                    if (rv_req == rv_req_ack) begin
                        if (rv_we) begin
                            rv_ready <= 1'b1;
                            rvst     <= RV_IDLE_REQ0;
                        end else begin
                            rvst <= RV_DATA1;
                        end
                    end
                end
                RV_DATA1: begin
                    rv_ready <= 1'b1;
                    rvst     <= RV_IDLE_REQ0;
                end
                default:
                    rvst <= RV_IDLE_REQ0;
            endcase
        end
    end

    // First read word is still on rv_dout in the cycle after its ack
    always_ff @(posedge mclk) begin
        if (rvst == RV_DATA0)
            rv_dout0 <= rv_dout;
    end

endmodule

// ==== rtl/snes_mem_top.sv ====
// Memory-request front end of the console
// Connects the ROM loader, the CPU-port request generator and the processor bridge
// to one external SDRAM controller

`include "snes_mem_config.svh"

module snes_mem_top import snes_mem_pkg::*; (
    input  logic                    mclk,
    input  logic                    resetn,
    // Loader and run control
    input  logic                    loading,
    input  byte_t                   loader_do,
    input  logic                    loader_do_valid,
    input  logic                    sdram_busy,
    input  logic                    frame_pause,
    output logic                    loaded,
    output logic                    enable,
    // Console ROM and work-RAM
    input  sd_addr_t                rom_addr,
    input  logic                    rom_ce_n,
    input  logic                    rom_word,
    output sd_word_t                rom_q,
    input  wram_addr_t              wram_addr,
    input  logic                    wram_ce_n,
    input  logic                    wram_rd_n,
    input  logic                    wram_we_n,
    input  byte_t                   wram_d,
    output byte_t                   wram_q,
    // SDRAM CPU port
    output logic                    cpu_req,
    output logic [`SD_ADDR_W-2:0]   cpu_addr,
    output sd_word_t                cpu_din,
    output logic                    cpu_we,
    output logic [1:0]              cpu_ds,
    output logic                    cpu_port,
    input  sd_word_t                cpu_port0,
    input  sd_word_t                cpu_port1,
    // System processor and SDRAM rv port
    input  logic                    rv_valid,
    input  sd_addr_t                rv_addr,
    input  rv_word_t                rv_wdata,
    input  logic [3:0]              rv_wstrb,
    output logic                    rv_ready,
    output rv_word_t                rv_rdata,
    output logic                    rv_req,
    input  logic                    rv_req_ack,
    output logic [`SD_ADDR_W-2:0]   rv_sd_addr,
    output sd_word_t                rv_din,
    output logic [1:0]              rv_ds,
    output logic                    rv_we,
    input  sd_word_t                rv_dout
);
    logic     loader_wr;
    sd_addr_t loader_waddr;
    sd_word_t loader_wdata;

    rom_loader rom_loader_i (
        .mclk(mclk), .resetn(resetn), .loading(loading),
        .loader_do(loader_do), .loader_do_valid(loader_do_valid),
        .sdram_busy(sdram_busy), .frame_pause(frame_pause),
        .loader_wr(loader_wr), .loader_waddr(loader_waddr), .loader_wdata(loader_wdata),
        .loaded(loaded), .enable(enable)
    );

    cpu_mem_req cpu_mem_req_i (
        .mclk(mclk), .resetn(resetn), .loading(loading),
        .loader_wr(loader_wr), .loader_waddr(loader_waddr), .loader_wdata(loader_wdata),
        .rom_addr(rom_addr), .rom_ce_n(rom_ce_n), .rom_word(rom_word),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n),
        .wram_we_n(wram_we_n), .wram_d(wram_d),
        .cpu_port0(cpu_port0), .cpu_port1(cpu_port1),
        .cpu_req(cpu_req), .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_we(cpu_we),
        .cpu_ds(cpu_ds), .cpu_port(cpu_port), .rom_q(rom_q), .wram_q(wram_q)
    );

    rv_bridge rv_bridge_i (
        .mclk(mclk), .resetn(resetn), .rv_valid(rv_valid), .rv_addr(rv_addr),
        .rv_wdata(rv_wdata), .rv_wstrb(rv_wstrb), .rv_req_ack(rv_req_ack),
        .rv_dout(rv_dout), .rv_ready(rv_ready), .rv_rdata(rv_rdata), .rv_req(rv_req),
        .rv_sd_addr(rv_sd_addr), .rv_din(rv_din), .rv_ds(rv_ds), .rv_we(rv_we)
    );

endmodule

// ==== dv/snes_mem_assertions.sv ====
// Concurrent checks on the memory-request front end
// Bound to snes_mem_top; counts its own assertion failures in fail_cnt

`include "snes_mem_config.svh"

module snes_mem_assertions import snes_mem_pkg::*; (
    input logic mclk, resetn, loading, loader_do_valid, loader_wr,
    input byte_t loader_do,
    input logic sdram_busy, frame_pause, loaded, enable,
    input sd_addr_t rom_addr,
    input logic rom_ce_n, rom_word,
    input sd_word_t rom_q,
    input wram_addr_t wram_addr,
    input logic wram_ce_n, wram_rd_n, wram_we_n,
    input byte_t wram_d, wram_q,
    input logic cpu_req, cpu_we, cpu_port,
    input logic [`SD_ADDR_W-2:0] cpu_addr, rv_sd_addr,
    input sd_word_t cpu_din, rv_din, rv_dout,
    input logic [1:0] cpu_ds, rv_ds,
    input logic rv_valid, rv_ready, rv_req, rv_req_ack, rv_we,
    input sd_addr_t rv_addr,
    input rv_word_t rv_wdata,
    input logic [3:0] rv_wstrb,
    input rv_word_t rv_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    int       fail_cnt = 0;
    logic     loading_r, rom_seen, wr_seen, rv_valid_r, rv_req_r, ack_r;
    sd_addr_t byte_cnt, last_rom;
    byte_t    last_byte, wr_byte;
    wram_addr_t wr_addr;
    int       rv_cnt;
    sd_word_t half [2];    // Words returned at each ack, by half
    sd_word_t rom_img [8];    // Loader words in the first 16 ROM bytes
    sd_word_t rom_exp;
    logic     rom_new, wram_rd, wram_wr, quiet;
    logic     wr_acc, exp_hi;
    logic [1:0] exp_ds;

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;
    assign rom_new = ~loading & ~rom_ce_n & (~rom_seen | (rom_addr != last_rom));
    assign quiet   = ~rom_new & ~loader_wr & wram_ce_n;
    assign rom_exp = rom_img[rom_addr[3:1]];
    assign wr_acc  = rv_wstrb != 4'b0000;
    assign exp_hi  = (rv_cnt == 0) ? (wr_acc && rv_wstrb[1:0] == 2'b00) : 1'b1;
    assign exp_ds  = !wr_acc ? 2'b11 : (exp_hi ? rv_wstrb[3:2] : rv_wstrb[1:0]);

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            byte_cnt  <= '0;
            rom_seen  <= 1'b0;
            wr_seen   <= 1'b0;
            rv_valid_r <= 1'b0;
            rv_req_r  <= 1'b0;
            ack_r     <= 1'b0;
            rv_cnt    <= 0;
        end else begin
            loading_r  <= loading;
            rv_valid_r <= rv_valid;
            rv_req_r   <= rv_req;
            ack_r      <= rv_req_ack;
            if (loading & ~loading_r)
                byte_cnt <= '0;
            else if (loader_do_valid)
                byte_cnt <= byte_cnt + `SD_ADDR_W'(1);
            if (loader_do_valid)
                last_byte <= loader_do;
            if (loading && loader_do_valid && byte_cnt[0] && byte_cnt[`SD_ADDR_W-1:4] == '0)
                rom_img[byte_cnt[3:1]] <= {loader_do, last_byte};
            if (loading)
                rom_seen <= 1'b0;
            else if (rom_new & wram_ce_n) begin
                rom_seen <= 1'b1;
                last_rom <= rom_addr;
            end
            if (wram_wr) begin
                wr_seen <= 1'b1;
                wr_addr <= wram_addr;
                wr_byte <= wram_d;
            end
            if (rv_valid & ~rv_valid_r)
                rv_cnt <= 0;
            else if (rv_req != rv_req_r)
                rv_cnt <= rv_cnt + 1;
            if (rv_req_ack != ack_r)
                half[rv_sd_addr[0]] <= rv_dout;
        end
    end

    // Reset values, checked on the first cycle out of reset
    a_reset: assert property (@(posedge mclk) $rose(resetn) |->
        !cpu_req && !rv_req && !rv_ready && !loaded && !enable)
        else begin $error("outputs not cleared by reset"); fail_cnt++; end

    a_loader: assert property (@(posedge mclk) disable iff (!resetn)
        loading && loader_do_valid && byte_cnt[0] |=> $changed(cpu_req) && cpu_we
        && cpu_ds == 2'b11 && !cpu_port && cpu_addr == $past(byte_cnt[`SD_ADDR_W-1:1])
        && cpu_din == {$past(loader_do), $past(last_byte)})
        else begin $error("Error cpu_din %h cpu_addr %h on loader write", cpu_din, cpu_addr);
            fail_cnt++; end

    a_quiet: assert property (@(posedge mclk) disable iff (!resetn)
        quiet && $past(wram_ce_n) |=> $stable(cpu_req))
        else begin $error("cpu_req toggled with no request pending"); fail_cnt++; end

    a_loaded: assert property (@(posedge mclk) disable iff (!resetn) $fell(loading) |=> loaded)
        else begin $error("loaded not set after loading"); fail_cnt++; end

    a_enable: assert property (@(posedge mclk) disable iff (!resetn)
        1'b1 |=> enable == $past(!sdram_busy && !frame_pause && loaded))
        else begin $error("Error enable %h", enable); fail_cnt++; end

    a_enable_load: assert property (@(posedge mclk) disable iff (!resetn)
        loading && $past(loading) && $past(loading, 2) |-> !enable)
        else begin $error("enable high during loading"); fail_cnt++; end

    a_rom_req: assert property (@(posedge mclk) disable iff (!resetn)
        rom_new && wram_ce_n |=> $changed(cpu_req) && !cpu_we && !cpu_port
        && cpu_ds == 2'b11 && cpu_addr == $past(rom_addr[`SD_ADDR_W-1:1]))
        else begin $error("Error cpu_addr %h on ROM read", cpu_addr); fail_cnt++; end

    // Loaded word comes back once the read has been served
    a_rom_q: assert property (@(posedge mclk) disable iff (!resetn)
        !rom_ce_n && !$past(rom_ce_n) && $stable(rom_addr) && rom_addr[`SD_ADDR_W-1:4] == '0
        |-> rom_q == ((rom_word || !rom_addr[0]) ? rom_exp : {rom_exp[7:0], rom_exp[15:8]}))
        else begin $error("Error rom_q %h word %h", rom_q, rom_exp); fail_cnt++; end

    a_wram_wr: assert property (@(posedge mclk) disable iff (!resetn)
        $rose(wram_wr) |=> $changed(cpu_req) && cpu_we && cpu_port
        && cpu_addr == {`WRAM_BANK_PREFIX, $past(wram_addr[`WRAM_ADDR_W-1:1])}
        && cpu_ds == {$past(wram_addr[0]), !$past(wram_addr[0])}
        && cpu_din == {2{$past(wram_d)}})
        else begin $error("Error cpu_addr %h cpu_din %h on work-RAM write", cpu_addr, cpu_din);
            fail_cnt++; end

    a_wram_rd: assert property (@(posedge mclk) disable iff (!resetn)
        $rose(wram_rd) |=> $changed(cpu_req) && !cpu_we && cpu_port)
        else begin $error("work-RAM read raised no request"); fail_cnt++; end

    a_wram_q: assert property (@(posedge mclk) disable iff (!resetn)
        wr_seen && wram_rd && $past(wram_rd) && $past(wram_rd, 2) && $past(wram_rd, 3)
        && wram_addr == wr_addr && $past(wram_addr, 3) == wram_addr |-> wram_q == wr_byte)
        else begin $error("Error wram_q %h expected %h", wram_q, wr_byte); fail_cnt++; end

    // Lower half first except for an upper-only write
    a_rv_half: assert property (@(posedge mclk) disable iff (!resetn)
        $changed(rv_req) |-> rv_we == wr_acc && rv_ds == exp_ds
        && rv_sd_addr == {rv_addr[`SD_ADDR_W-1:2], exp_hi}
        && (!wr_acc || rv_din == (exp_hi ? rv_wdata[31:16] : rv_wdata[15:0])))
        else begin
            $error("Error rv_sd_addr %h rv_ds %h rv_din %h", rv_sd_addr, rv_ds, rv_din);
            fail_cnt++;
        end

    a_rv_count: assert property (@(posedge mclk) disable iff (!resetn)
        rv_ready |-> rv_cnt == ((wr_acc && (rv_wstrb[1:0] == 2'b00 || rv_wstrb[3:2] == 2'b00))
                                ? 1 : 2))
        else begin $error("Error rv_req toggles %h", rv_cnt); fail_cnt++; end

    a_rv_rdata: assert property (@(posedge mclk) disable iff (!resetn)
        rv_ready && !wr_acc |-> rv_rdata == {half[1], half[0]})
        else begin $error("Error rv_rdata %h expected %h", rv_rdata, {half[1], half[0]});
            fail_cnt++; end

    a_rv_pulse: assert property (@(posedge mclk) disable iff (!resetn) rv_ready |=> !rv_ready)
        else begin $error("rv_ready held longer than one cycle"); fail_cnt++; end

endmodule

bind snes_mem_top snes_mem_assertions snes_mem_assertions_i (.*);

// ==== dv/snes_mem_tb.sv ====
// Testbench for the memory-request front end
// Models the SDRAM controller, drives loader, console and processor traffic;
// the bound assertions do the checking

`include "snes_mem_config.svh"

module snes_mem_tb;
    import snes_mem_pkg::*;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int STIM_CYCLES = 300;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES;

    logic mclk = 1'b0, resetn = 1'b0;
    logic loading, loader_do_valid, sdram_busy, frame_pause, loaded, enable;
    byte_t loader_do, wram_d, wram_q;
    sd_addr_t rom_addr, rv_addr;
    logic rom_ce_n, rom_word, wram_ce_n, wram_rd_n, wram_we_n;
    sd_word_t rom_q, cpu_din, cpu_port0, cpu_port1, rv_din, rv_dout;
    wram_addr_t wram_addr;
    logic cpu_req, cpu_we, cpu_port, rv_valid, rv_ready, rv_req, rv_req_ack, rv_we;
    logic [`SD_ADDR_W-2:0] cpu_addr, rv_sd_addr;
    logic [1:0] cpu_ds, rv_ds;
    rv_word_t rv_wdata, rv_rdata;
    logic [3:0] rv_wstrb;
    logic cpu_req_seen = 1'b0;
    sd_word_t mem [logic [21:0]];
    int tb_errors = 0;
    int cycles = 0;

    snes_mem_top snes_mem_top_i (.*);

    always #10 mclk = ~mclk;

    function automatic sd_word_t read_word(logic [21:0] a);
        if (mem.exists(a))
            return mem[a];
        return {a[7:0] ^ a[21:14], a[15:8] ^ 8'h5a};    // Fill uses every address bit
    endfunction

    task automatic write_word(logic [21:0] a, sd_word_t d, logic [1:0] ds);
        sd_word_t w;
        w = read_word(a);
        if (ds[0]) w[7:0] = d[7:0];
        if (ds[1]) w[15:8] = d[15:8];
        mem[a] = w;
    endtask

    // CPU port served on the falling edge after each toggle
    always @(negedge mclk) begin
        if (resetn && cpu_req != cpu_req_seen) begin
            cpu_req_seen = cpu_req;
            if (cpu_we)
                write_word(cpu_addr, cpu_din, cpu_ds);
            else if (cpu_port)
                cpu_port1 = read_word(cpu_addr);
            else
                cpu_port0 = read_word(cpu_addr);
        end
    end

    // rv port with a random service delay
    initial begin
        forever begin
            @(negedge mclk);
            if (resetn && rv_req != rv_req_ack) begin
                repeat ($urandom_range(6, 1)) @(negedge mclk);
                if (rv_we)
                    write_word(rv_sd_addr, rv_din, rv_ds);
                else
                    rv_dout = read_word(rv_sd_addr);
                rv_req_ack = rv_req;
            end
        end
    end

    always @(posedge mclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // One loading window with a valid byte every other cycle
    task automatic load_image(int nbytes);
        loading = 1'b1;
        repeat (2) @(negedge mclk);
        for (int i = 0; i < nbytes; i++) begin
            loader_do       = byte_t'($urandom);
            loader_do_valid = 1'b1;
            @(negedge mclk);
            loader_do_valid = 1'b0;
            @(negedge mclk);
        end
        loading = 1'b0;
        repeat (3) @(negedge mclk);
    endtask

    task automatic bridge_access(sd_addr_t a, rv_word_t d, logic [3:0] strb);
        bit seen;
        seen = 1'b0;
        rv_addr  = a;
        rv_wdata = d;
        rv_wstrb = strb;
        rv_valid = 1'b1;
        for (int i = 0; i < 40 && !seen; i++) begin
            @(negedge mclk);
            seen = rv_ready;
        end
        if (!seen) begin
            tb_errors++;
            $display("rv_ready never arrived for bridge access at %h", a);
        end
        rv_valid = 1'b0;
        repeat (2) @(negedge mclk);
    endtask

    task automatic wram_cycle(wram_addr_t a, byte_t d, bit wr, int n);
        wram_addr = a;
        wram_d    = d;
        wram_ce_n = 1'b0;
        wram_we_n = !wr;
        wram_rd_n = wr;
        repeat (n) @(negedge mclk);
        wram_ce_n = 1'b1;
        wram_we_n = 1'b1;
        wram_rd_n = 1'b1;
        @(negedge mclk);
    endtask

    initial begin
        void'($urandom(7));
        {loading, loader_do_valid, sdram_busy, frame_pause, loader_do} = '0;
        {rom_addr, rom_word, wram_addr, wram_d, rv_valid, rv_addr, rv_wdata, rv_wstrb} = '0;
        {rom_ce_n, wram_ce_n, wram_rd_n, wram_we_n} = 4'hf;
        {cpu_port0, cpu_port1, rv_dout, rv_req_ack} = '0;
        repeat (4) @(negedge mclk);
        resetn = 1'b1;
        sdram_busy = 1'b1;
        @(negedge mclk);
        load_image(16);
        sdram_busy  = 1'b0;
        frame_pause = 1'b1;
        repeat (3) @(negedge mclk);
        frame_pause = 1'b0;
        repeat (3) @(negedge mclk);
        // ROM reads, each held so that the repeat sends nothing
        rom_ce_n = 1'b0;
        rom_word = 1'b1;
        rom_addr = 23'h000002;
        repeat (4) @(negedge mclk);
        rom_word = 1'b0;
        rom_addr = 23'h000005;
        repeat (4) @(negedge mclk);
        rom_word = 1'b1;
        repeat (2) @(negedge mclk);
        rom_addr = 23'h000006;
        repeat (4) @(negedge mclk);
        rom_ce_n = 1'b1;
        @(negedge mclk);
        wram_cycle(17'h00123, 8'ha5, 1'b1, 2);
        wram_cycle(17'h00123, 8'h00, 1'b0, 6);
        wram_cycle(17'h1fffe, 8'h3c, 1'b1, 2);
        wram_cycle(17'h1fffe, 8'h00, 1'b0, 6);
        bridge_access(23'h000100, 32'h0, 4'b0000);
        bridge_access(23'h000200, 32'h1234_5678, 4'b0011);
        bridge_access(23'h000200, 32'h9abc_def0, 4'b1100);
        bridge_access(23'h000204, 32'hcafe_f00d, 4'b1111);
        bridge_access(23'h000200, 32'h0, 4'b0000);
        bridge_access(23'h000204, 32'h0, 4'b0000);
        // Reload while running, enable has to drop
        load_image(4);
        repeat (4) @(negedge mclk);
        $display("Errors: %0d testbench, %0d assertion", tb_errors,
                 snes_mem_top_i.snes_mem_assertions_i.fail_cnt);
        if (tb_errors + snes_mem_top_i.snes_mem_assertions_i.fail_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== snes_mem.f ====
+incdir+include
rtl/snes_mem_pkg.sv
rtl/rom_loader.sv
rtl/cpu_mem_req.sv
rtl/rv_bridge.sv
rtl/snes_mem_top.sv
dv/snes_mem_assertions.sv
dv/snes_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= snes_mem_tb
RTL_TOP   ?= snes_mem_top
FLIST     ?= snes_mem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
